//--- include/fetch_defs.svh
/*
 * shared defines for the fetch loop RTL and its testbench
 * memory words are 64 bits wide, instructions 32 bits, PCs byte addresses
 */
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

`define IMEM_WORD_OFFSET   3    // byte offset bits inside one 64-bit memory word
`define INST_BYTES         4    // one RV instruction, step of the sequential PC
`define IMEM_WORDS_DEFAULT 256  // default memory depth in 64-bit words

`endif

//--- hdl/fetch_pkg.sv
/*
 * common types for the single-issue RV64 fetch loop
 * only JAL and B-type opcodes are decoded, everything else falls through
 * every packet valid is a one-cycle strobe with no back-pressure
 */
package fetch_pkg;

  localparam int xlen = 64;  // address and data width

  localparam logic [6:0] opcode_jal    = 7'b110_1111;
  localparam logic [6:0] opcode_branch = 7'b110_0011;

  ////////////////////////////////////////////////////////////////////////////
  // stage packets
  ////////////////////////////////////////////////////////////////////////////

  // fetch -> execute
  typedef struct packed {
    logic            valid;
    logic [31:0]     inst;
    logic [xlen-1:0] pc;    // pc of inst
    logic [xlen-1:0] npc;   // pc + 4
  } f_d_packet_t;

  // execute -> completion, also the redirect back into fetch
  typedef struct packed {
    logic            valid;
    logic            take_branch;  // redirect strobe
    logic [xlen-1:0] alu_result;   // target when taken, npc otherwise
    logic [xlen-1:0] pc;
    logic [31:0]     inst;
  } x_c_packet_t;

  // completion -> fetch
  typedef struct packed {
    logic valid;  // instruction done, fetch may go again
  } c_r_packet_t;

endpackage

//--- hdl/if_stage.sv
/*
 * fetch stage, one instruction in flight at a time
 * reads 64-bit memory words and picks the half addressed by pc bit 2
 * redirect targets are assumed 4-byte aligned, no fault is raised otherwise
 * after a fetch it waits for the completion strobe before fetching again
 */
`timescale 1ns/1ps
`include "fetch_defs.svh"

module if_stage import fetch_pkg::*; (
  input  logic            clock,
  input  logic            reset,
  input  c_r_packet_t     c_r_packet,      // completion, re-arms fetch
  input  x_c_packet_t     x_c_packet,      // redirect from execute
  input  logic [xlen-1:0] imem2proc_data,  // whole 64-bit word
  input  logic            imem_valid,
  output logic [xlen-1:0] proc2imem_addr,
  output f_d_packet_t     f_packet
);

  // clears the byte offset inside a memory word
  localparam logic [xlen-1:0] word_mask = ~((xlen'(1) << `IMEM_WORD_OFFSET) - xlen'(1));

  logic [xlen-1:0] pc_reg;           // pc being fetched
  logic [xlen-1:0] pc_plus_4;
  logic [xlen-1:0] next_pc;
  logic            pc_enable;
  logic            ready_for_valid;  // no instruction in flight
  logic            next_ready_for_valid;

  assign proc2imem_addr = pc_reg & word_mask;  // memory wants word aligned

  assign pc_plus_4 = pc_reg + xlen'(`INST_BYTES);

  // upper half when pc bit 2 is set
  assign f_packet.inst  = pc_reg[`IMEM_WORD_OFFSET-1] ? imem2proc_data[63:32]
                                                      : imem2proc_data[31:0];
  assign f_packet.pc    = pc_reg;
  assign f_packet.npc   = pc_plus_4;
  assign f_packet.valid = ready_for_valid && imem_valid;  // fetch happens here

  ////////////////////////////////////////////////////////////////////////////
  // next pc
  ////////////////////////////////////////////////////////////////////////////

  assign next_pc = x_c_packet.take_branch ? x_c_packet.alu_result : pc_plus_4;

  // a redirect arrives while stalled, so it must get past the stall
  assign pc_enable = f_packet.valid || x_c_packet.take_branch;

  always_ff @(posedge clock) begin
    if (reset) begin
      pc_reg <= '0;  // boot from address 0
    end else if (pc_enable) begin
      pc_reg <= next_pc;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // single-issue stall
  ////////////////////////////////////////////////////////////////////////////

  // drop on a fetch, rise again on completion
  assign next_ready_for_valid = (ready_for_valid || c_r_packet.valid) && !f_packet.valid;

  always_ff @(posedge clock) begin
    if (reset) begin
      ready_for_valid <= 1'b1;  // first fetch needs no completion
    end else begin
      ready_for_valid <= next_ready_for_valid;
    end
  end

endmodule

//--- hdl/ex_stage.sv
/*
 * execute stage, control flow only
 * JAL is always taken, a B-type branch is taken when rs1 and rs2 match
 * there is no register file, so equal register numbers stand for equal operands
 * every other opcode falls through with alu_result = npc
 */
`timescale 1ns/1ps

module ex_stage import fetch_pkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  f_d_packet_t f_packet,
  output x_c_packet_t x_c_packet
);

  logic            d_valid;  // fetched packet held one cycle
  logic [31:0]     d_inst;
  logic [xlen-1:0] d_pc;
  logic [xlen-1:0] d_npc;

  logic [6:0]      opcode;
  logic [4:0]      rs1;
  logic [4:0]      rs2;
  logic            is_jal;
  logic            is_branch;
  logic            rs_equal;
  logic [xlen-1:0] j_imm;
  logic [xlen-1:0] b_imm;
  logic [xlen-1:0] imm;
  logic            take;

  ////////////////////////////////////////////////////////////////////////////
  // input register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      d_valid <= 1'b0;
    end else begin
      d_valid <= f_packet.valid;
    end
  end

  // payload only moves with a fetch
  always_ff @(posedge clock) begin
    if (f_packet.valid) begin
      d_inst <= f_packet.inst;
      d_pc   <= f_packet.pc;
      d_npc  <= f_packet.npc;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // decode
  ////////////////////////////////////////////////////////////////////////////

  assign opcode = d_inst[6:0];
  assign rs1    = d_inst[19:15];
  assign rs2    = d_inst[24:20];

  assign is_jal    = (opcode == opcode_jal);
  assign is_branch = (opcode == opcode_branch);
  assign rs_equal  = (rs1 == rs2);  // stands in for the operand compare

  // J-type: imm[20|10:1|11|19:12], bit 0 always zero
  assign j_imm = {{(xlen-21){d_inst[31]}}, d_inst[31], d_inst[19:12], d_inst[20],
                  d_inst[30:21], 1'b0};

  // B-type: imm[12|10:5] in the top, imm[4:1|11] in the rd slot
  assign b_imm = {{(xlen-13){d_inst[31]}}, d_inst[31], d_inst[7], d_inst[30:25],
                  d_inst[11:8], 1'b0};

  assign imm  = is_jal ? j_imm : b_imm;
  assign take = d_valid && (is_jal || (is_branch && rs_equal));  // no stale redirects

  ////////////////////////////////////////////////////////////////////////////
  // output packet
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    x_c_packet.valid       = d_valid;
    x_c_packet.take_branch = take;
    x_c_packet.alu_result  = take ? (d_pc + imm) : d_npc;  // target or fall through
    x_c_packet.pc          = d_pc;
    x_c_packet.inst        = d_inst;
  end

endmodule

//--- hdl/retire_stage.sv
/*
 * completion stage
 * retires one instruction one cycle after execute and re-arms fetch
 * retire_count wraps at 2^32 and is already updated in the retire cycle
 */
`timescale 1ns/1ps

module retire_stage import fetch_pkg::*; (
  input  logic            clock,
  input  logic            reset,
  input  x_c_packet_t     x_c_packet,
  output c_r_packet_t     c_r_packet,
  output logic            retire_valid,
  output logic [xlen-1:0] retire_pc,
  output logic [31:0]     retire_inst,
  output logic [31:0]     retire_count
);

  logic done;  // one-cycle completion strobe

  always_ff @(posedge clock) begin
    if (reset) begin
      done         <= 1'b0;
      retire_count <= '0;
    end else begin
      done <= x_c_packet.valid;
      if (x_c_packet.valid) begin
        retire_count <= retire_count + 32'd1;  // counts with the strobe
      end
    end
  end

  // pc and inst only change when something retires
  always_ff @(posedge clock) begin
    if (x_c_packet.valid) begin
      retire_pc   <= x_c_packet.pc;
      retire_inst <= x_c_packet.inst;
    end
  end

  assign c_r_packet.valid = done;  // back to fetch
  assign retire_valid     = done;

endmodule

//--- hdl/imem.sv
/*
 * instruction memory model, 64-bit words, combinational read
 * addr and load_addr are byte addresses, bits 2:0 are ignored
 * the word index wraps modulo imem_words
 * valid drops for imem_latency cycles after reset or any address change
 * imem_latency must be at least 1
 */
`timescale 1ns/1ps
`include "fetch_defs.svh"

module imem import fetch_pkg::*; #(
  parameter int imem_words   = `IMEM_WORDS_DEFAULT,
  parameter int imem_latency = 2
) (
  input  logic            clock,
  input  logic            reset,
  input  logic [xlen-1:0] addr,
  input  logic            load_en,    // testbench image load
  input  logic [xlen-1:0] load_addr,
  input  logic [xlen-1:0] load_data,
  output logic [xlen-1:0] data,
  output logic            valid
);

  localparam int idx_w = (imem_words > 1) ? $clog2(imem_words) : 1;
  localparam int cnt_w = $clog2(imem_latency + 1);

  logic [xlen-1:0]  mem [imem_words];
  logic [idx_w-1:0] rd_idx;
  logic [idx_w-1:0] wr_idx;
  logic [xlen-1:0]  prev_addr;  // address seen last cycle
  logic             addr_changed;
  logic [cnt_w-1:0] wait_cnt;   // cycles left before data is good

  // word number modulo depth, also right for odd depths
  assign rd_idx = idx_w'((addr >> `IMEM_WORD_OFFSET) % imem_words);
  assign wr_idx = idx_w'((load_addr >> `IMEM_WORD_OFFSET) % imem_words);

  ////////////////////////////////////////////////////////////////////////////
  // storage
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (load_en) begin
      mem[wr_idx] <= load_data;
    end
  end

  assign data = mem[rd_idx];

  ////////////////////////////////////////////////////////////////////////////
  // latency model
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    prev_addr <= addr;
  end

  assign addr_changed = (addr != prev_addr);  // the change cycle counts as one

  always_ff @(posedge clock) begin
    if (reset) begin
      wait_cnt <= cnt_w'(imem_latency);  // full wait out of reset
    end else if (addr_changed) begin
      wait_cnt <= cnt_w'(imem_latency - 1);
    end else if (wait_cnt != '0) begin
      wait_cnt <= wait_cnt - cnt_w'(1);
    end
  end

  assign valid = !addr_changed && (wait_cnt == '0);  // held until addr moves

endmodule

//--- hdl/fetch_loop_top.sv
/*
 * single-issue RV64 fetch loop: fetch, memory, execute, completion
 * the program image goes in through the load port, normally during reset
 * load_addr is a byte address of a 64-bit word
 * the retire_* outputs show one instruction per retire_valid strobe
 */
`timescale 1ns/1ps
`include "fetch_defs.svh"

module fetch_loop_top import fetch_pkg::*; #(
  parameter int imem_words   = `IMEM_WORDS_DEFAULT,
  parameter int imem_latency = 2
) (
  input  logic            clock,
  input  logic            reset,
  input  logic            load_en,
  input  logic [xlen-1:0] load_addr,
  input  logic [xlen-1:0] load_data,
  output logic            retire_valid,
  output logic [xlen-1:0] retire_pc,
  output logic [31:0]     retire_inst,
  output logic [31:0]     retire_count
);

  logic [xlen-1:0] proc2imem_addr;
  logic [xlen-1:0] imem2proc_data;
  logic            imem_valid;
  f_d_packet_t     f_packet;
  x_c_packet_t     x_c_packet;  // to completion and back to fetch
  c_r_packet_t     c_r_packet;

  if_stage u_if (
    .clock          (clock),
    .reset          (reset),
    .c_r_packet     (c_r_packet),
    .x_c_packet     (x_c_packet),
    .imem2proc_data (imem2proc_data),
    .imem_valid     (imem_valid),
    .proc2imem_addr (proc2imem_addr),
    .f_packet       (f_packet)
  );

  imem #(
    .imem_words   (imem_words),
    .imem_latency (imem_latency)
  ) u_imem (
    .clock     (clock),
    .reset     (reset),
    .addr      (proc2imem_addr),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .data      (imem2proc_data),
    .valid     (imem_valid)
  );

  ex_stage u_ex (
    .clock      (clock),
    .reset      (reset),
    .f_packet   (f_packet),
    .x_c_packet (x_c_packet)
  );

  retire_stage u_retire (
    .clock        (clock),
    .reset        (reset),
    .x_c_packet   (x_c_packet),
    .c_r_packet   (c_r_packet),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc),
    .retire_inst  (retire_inst),
    .retire_count (retire_count)
  );

endmodule

//--- test/fetch_loop_props.sv
/*
 * assertions on the fetch stage, bound into every if_stage
 * failures go out through $error and are tallied in assert_fails
 */
`timescale 1ns/1ps

module fetch_loop_props import fetch_pkg::*; (
  input logic            clock,
  input logic            reset,
  input logic            ready_for_valid,
  input logic [xlen-1:0] pc_reg,
  input f_d_packet_t     f_packet,
  input x_c_packet_t     x_c_packet
);

  int assert_fails = 0;  // read by the testbench at the end

  // single issue, the stall holds while the fetched instruction executes and retires
  no_fetch_while_stalled: assert property (@(posedge clock) disable iff (reset)
    f_packet.valid |=> !ready_for_valid ##1 !ready_for_valid
  ) else begin
    $error("fetch stage re-armed while an instruction is in flight");
    assert_fails++;
  end

  // redirect lands on the target one cycle later
  redirect_loads_target: assert property (@(posedge clock) disable iff (reset)
    x_c_packet.take_branch |=> pc_reg == $past(x_c_packet.alu_result)
  ) else begin
    $error("pc %h is not the redirect target", pc_reg);
    assert_fails++;
  end

  // no fetch and no redirect, pc stays put
  pc_holds_when_idle: assert property (@(posedge clock) disable iff (reset)
    !f_packet.valid && !x_c_packet.take_branch |=> $stable(pc_reg)
  ) else begin
    $error("pc moved without a fetch or redirect");
    assert_fails++;
  end

  // plain fetch steps by one instruction
  fetch_steps_by_4: assert property (@(posedge clock) disable iff (reset)
    f_packet.valid && !x_c_packet.take_branch |=> pc_reg == $past(pc_reg) + 64'd4
  ) else begin
    $error("pc did not step by 4 after a fetch");
    assert_fails++;
  end

endmodule

bind if_stage fetch_loop_props u_props (
  .clock           (clock),
  .reset           (reset),
  .ready_for_valid (ready_for_valid),
  .pc_reg          (pc_reg),
  .f_packet        (f_packet),
  .x_c_packet      (x_c_packet)
);

//--- test/fetch_loop_tb.sv
/*
 * testbench for the single-issue fetch loop
 * a fixed-seed LCG builds a random 256-word image, loaded during reset
 * a reference PC walker gives the expected retire stream
 * retire order, spacing and count are checked, exact fetch timing is not modeled
 */
`timescale 1ns/1ps
`include "fetch_defs.svh"

module fetch_loop_tb import fetch_pkg::*; ();

  localparam int          num_words      = `IMEM_WORDS_DEFAULT;
  localparam int          num_slots      = num_words * 2;    // two instructions per word
  localparam int          num_insts      = 300;              // retirements to check
  localparam int          timeout_cycles = num_insts * 12;
  localparam int          latency        = 2;
  localparam int          reset_cycles   = 3;
  localparam logic [31:0] seed           = 32'hd3b9_30ca;

  localparam int kind_plain  = 0;
  localparam int kind_jal    = 1;
  localparam int kind_branch = 2;

  // one expected retirement
  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [31:0]     inst;
  } retire_rec_t;

  logic            clock;
  logic            reset;
  logic            load_en;
  logic [xlen-1:0] load_addr;
  logic [xlen-1:0] load_data;
  logic            retire_valid;
  logic [xlen-1:0] retire_pc;
  logic [31:0]     retire_inst;
  logic [31:0]     retire_count;

  logic [31:0]     slot_inst   [num_slots];
  int              slot_kind   [num_slots];
  int              slot_offset [num_slots];  // byte offset of jal / branch target
  logic            slot_equal  [num_slots];  // branch has rs1 == rs2
  logic [xlen-1:0] image       [num_words];
  retire_rec_t     expected    [num_insts];

  logic [31:0] rng_state;
  int          errors;

  fetch_loop_top #(
    .imem_words   (num_words),
    .imem_latency (latency)
  ) DUT (
    .clock        (clock),
    .reset        (reset),
    .load_en      (load_en),
    .load_addr    (load_addr),
    .load_data    (load_data),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc),
    .retire_inst  (retire_inst),
    .retire_count (retire_count)
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;  // 40 ns period
  end

  ////////////////////////////////////////////////////////////////////////////
  // random numbers and instruction encoding
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // low LCG bits are weak, use the upper ones
  function automatic int rand_below(input int n);
    logic [31:0] r;
    r = lcg_next();
    return int'(r[31:8]) % n;
  endfunction

  // J-type: imm[20|10:1|11|19:12] rd opcode
  function automatic logic [31:0] encode_jal(input int offset, input logic [4:0] rd);
    logic [20:0] imm;
    imm = 21'(offset);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opcode_jal};
  endfunction

  // B-type: imm[12|10:5] rs2 rs1 funct3 imm[4:1|11] opcode
  function automatic logic [31:0] encode_branch(input int offset, input logic [4:0] rs1,
                                                input logic [4:0] rs2, input logic [2:0] funct3);
    logic [12:0] imm;
    imm = 13'(offset);
    return {imm[12], imm[10:5], rs2, rs1, funct3, imm[4:1], imm[11], opcode_branch};
  endfunction

  // mostly forward, never zero, target always inside the image
  function automatic int pick_offset(input int slot);
    int k;
    k = rand_below(32) - 8;
    if (k == 0) begin
      k = 1;
    end
    if (slot + k < 0 || slot + k >= num_slots) begin
      k = -k;  // mirror back into range
    end
    return k * 4;
  endfunction

  task automatic build_image();
    int          kind;
    logic [31:0] r;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [6:0]  op;
    for (int s = 0; s < num_slots; s++) begin
      kind           = rand_below(4);  // half plain, a quarter each jal and branch
      slot_equal[s]  = 1'b0;
      slot_offset[s] = 0;
      if (kind < 2) begin
        case (rand_below(4))
          0:       op = 7'b001_0011;  // op-imm
          1:       op = 7'b011_0011;  // op
          2:       op = 7'b011_0111;  // lui
          default: op = 7'b000_0011;  // load
        endcase
        r            = lcg_next();
        slot_kind[s] = kind_plain;
        slot_inst[s] = {r[31:7], op};
      end else if (kind == 2) begin
        slot_kind[s]   = kind_jal;
        slot_offset[s] = pick_offset(s);
        slot_inst[s]   = encode_jal(slot_offset[s], 5'(rand_below(32)));
      end else begin
        slot_kind[s]   = kind_branch;
        slot_offset[s] = pick_offset(s);
        slot_equal[s]  = (rand_below(2) == 1);
        rs1            = 5'(rand_below(32));
        rs2            = slot_equal[s] ? rs1 : rs1 ^ 5'(1 + rand_below(31));
        slot_inst[s]   = encode_branch(slot_offset[s], rs1, rs2, 3'(rand_below(8)));
      end
    end
    for (int w = 0; w < num_words; w++) begin
      image[w] = {slot_inst[2*w+1], slot_inst[2*w]};  // even slot in the low half
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // reference pc walker
  ////////////////////////////////////////////////////////////////////////////

  task automatic build_model();
    longint pc;
    int     slot;
    int     n_jal;
    int     n_taken;
    int     n_not_taken;
    int     n_upper;
    pc          = 0;  // boot address
    n_jal       = 0;
    n_taken     = 0;
    n_not_taken = 0;
    n_upper     = 0;
    for (int i = 0; i < num_insts; i++) begin
      slot             = int'((pc / 4) % num_slots);  // memory index wraps
      expected[i].pc   = xlen'(pc);
      expected[i].inst = slot_inst[slot];
      if (pc[2]) begin
        n_upper++;
      end
      if (slot_kind[slot] == kind_jal) begin
        n_jal++;
        pc = pc + slot_offset[slot];
      end else if (slot_kind[slot] == kind_branch && slot_equal[slot]) begin
        n_taken++;
        pc = pc + slot_offset[slot];
      end else begin
        if (slot_kind[slot] == kind_branch) begin
          n_not_taken++;
        end
        pc = pc + 4;
      end
    end
    $display("model: %0d jal, %0d branch taken, %0d branch not taken, %0d upper half",
             n_jal, n_taken, n_not_taken, n_upper);
  endtask

  task automatic check_value(input string name, input logic [63:0] exp_value,
                             input logic [63:0] act_value);
    if (act_value !== exp_value) begin
      $display("FAILED %s expected %h actual %h", name, exp_value, act_value);
      errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus and retire monitor
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int   n_retired;
    int   cycles;
    int   last_retire;
    int   assert_fails;
    logic prev_valid;

    reset     = 1'b1;
    load_en   = 1'b0;
    load_addr = '0;
    load_data = '0;
    errors    = 0;
    rng_state = seed;

    build_image();
    build_model();

    // image goes in under reset, one word per falling edge
    for (int w = 0; w < num_words; w++) begin
      @(negedge clock);
      load_en   = 1'b1;
      load_addr = xlen'(w * 8);  // byte address of the word
      load_data = image[w];
    end
    @(negedge clock);
    load_en = 1'b0;
    repeat (reset_cycles) @(negedge clock);
    reset = 1'b0;

    // nothing has moved since the last reset edge
    check_value("retire_valid", 64'(0), 64'(retire_valid));
    check_value("retire_count", 64'(0), 64'(retire_count));

    n_retired   = 0;
    cycles      = 0;
    last_retire = 0;
    prev_valid  = 1'b0;
    while (n_retired < num_insts && cycles < timeout_cycles) begin
      @(negedge clock);  // outputs settled since the rising edge
      cycles++;
      if (retire_valid && prev_valid) begin
        $display("retire_valid stayed high for two cycles after retirement %0d", n_retired);
        errors++;
      end else if (retire_valid) begin
        if (n_retired > 0 && cycles - last_retire < 3) begin
          $display("retirement %0d came %0d cycles after the previous one",
                   n_retired, cycles - last_retire);
          errors++;
        end
        if (n_retired == 0) begin
          check_value("retire_pc", 64'(0), retire_pc);        // boot pc
          check_value("retire_inst", 64'(image[0][31:0]), 64'(retire_inst));
        end
        check_value("retire_pc", expected[n_retired].pc, retire_pc);
        check_value("retire_inst", 64'(expected[n_retired].inst), 64'(retire_inst));
        check_value("retire_count", 64'(n_retired + 1), 64'(retire_count));
        last_retire = cycles;
        n_retired++;
      end
      prev_valid = retire_valid;
    end

    if (n_retired < num_insts) begin
      $display("timeout, only %0d of %0d instructions retired in %0d cycles",
               n_retired, num_insts, cycles);
      errors++;
    end else begin
      check_value("retire_count", 64'(num_insts), 64'(retire_count));
    end

    assert_fails = DUT.u_if.u_props.assert_fails;
    $display("errors: %0d checks, %0d assertions", errors, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- sim.f
+incdir+include
hdl/fetch_pkg.sv
hdl/if_stage.sv
hdl/ex_stage.sv
hdl/retire_stage.sv
hdl/imem.sv
hdl/fetch_loop_top.sv
test/fetch_loop_props.sv
test/fetch_loop_tb.sv

//--- Bender.yml
package:
  name: fetch_loop

export_include_dirs:
  - include

sources:
  - files:
      - hdl/fetch_pkg.sv
      - hdl/if_stage.sv
      - hdl/ex_stage.sv
      - hdl/retire_stage.sv
      - hdl/imem.sv
      - hdl/fetch_loop_top.sv
  - target: test
    files:
      - test/fetch_loop_props.sv
      - test/fetch_loop_tb.sv
